// ==== rtl/sha256_config.svh ====
`ifndef SHA256_CONFIG_SVH
`define SHA256_CONFIG_SVH

// width of one message and state word
`define SHA_WORD_W 32

// compression rounds per block
`define SHA_ROUNDS 64

// message schedule window, in words
`define SHA_WIN_DEPTH 16

`endif

// ==== rtl/sha_types_pkg.sv ====
`include "sha256_config.svh"

package sha_types_pkg;

	// one message or state word
	typedef logic [`SHA_WORD_W-1:0] sha_word_t;

	// 512-bit message block, word 0 in the top position
	typedef logic [0:`SHA_WIN_DEPTH-1][`SHA_WORD_W-1:0] sha_block_t;

	// round number 0..63
	typedef logic [$clog2(`SHA_ROUNDS)-1:0] sha_round_idx_t;

	// working variables, a in the top word
	typedef struct packed {
		sha_word_t a;
		sha_word_t b;
		sha_word_t c;
		sha_word_t d;
		sha_word_t e;
		sha_word_t f;
		sha_word_t g;
		sha_word_t h;
	} sha_state_s;

	// datapath reads the named words, ports carry the flat vector
	typedef union packed {
		sha_state_s named;
		logic [8*`SHA_WORD_W-1:0] flat;
	} sha_state_u;

endpackage

// ==== rtl/sha_const_pkg.sv ====
`include "sha256_config.svh"

package sha_const_pkg;

	////////////////////////////////////////////////////////////
	// round constants
	////////////////////////////////////////////////////////////

	// first 32 bits of the fractional parts of the cube roots of the first 64 primes
	localparam sha_types_pkg::sha_word_t sha_round_k [0:`SHA_ROUNDS-1] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	////////////////////////////////////////////////////////////
	// initial hash value
	////////////////////////////////////////////////////////////

	// H0..H7, a in the top word
	localparam sha_types_pkg::sha_state_u sha_iv = {
		32'h6a09e667,
		32'hbb67ae85,
		32'h3c6ef372,
		32'ha54ff53a,
		32'h510e527f,
		32'h9b05688c,
		32'h1f83d9ab,
		32'h5be0cd19
	};

endpackage

// ==== rtl/sha_ctrl.sv ====
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           en,
	output logic                           rdy,
	output logic                           load,
	output logic                           step,
	output sha_types_pkg::sha_round_idx_t  round_idx
);

	logic busy;
	logic done;
	logic last_round;

	// accept happens on the edge that ends this cycle
	assign load = en & rdy;

	// one round per busy cycle
	assign step = busy;

	assign last_round = (round_idx == sha_types_pkg::sha_round_idx_t'(`SHA_ROUNDS - 1));

	////////////////////////////////////////////////////////////
	// round sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			round_idx <= '0;
		end else if (load) begin
			busy      <= 1'b1;
			round_idx <= '0;
		end else if (step) begin
			round_idx <= round_idx + 1'b1;
			// busy drops with the edge that applies round 63
			if (last_round) begin
				busy <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// ready flag
	////////////////////////////////////////////////////////////

	// done pulses one cycle after the last round
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= step & last_round;
		end
	end

	// low from the accept edge until the edge after done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdy <= 1'b1;
		end else if (load) begin
			rdy <= 1'b0;
		end else if (done) begin
			rdy <= 1'b1;
		end
	end

endmodule

// ==== rtl/sha_msg_schedule.sv ====
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha_msg_schedule (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      load,
	input  logic                      step,
	input  sha_types_pkg::sha_block_t block,
	output sha_types_pkg::sha_word_t  w
);

	// win[0] holds W(t) during round t
	sha_types_pkg::sha_block_t win;
	sha_types_pkg::sha_word_t  w_new;

	////////////////////////////////////////////////////////////
	// small sigma functions
	////////////////////////////////////////////////////////////

	function automatic sha_types_pkg::sha_word_t ssig0(input sha_types_pkg::sha_word_t x);
		return ({x[6:0], x[31:7]}) ^ ({x[17:0], x[31:18]}) ^ (x >> 3);
	endfunction

	function automatic sha_types_pkg::sha_word_t ssig1(input sha_types_pkg::sha_word_t x);
		return ({x[16:0], x[31:17]}) ^ ({x[18:0], x[31:19]}) ^ (x >> 10);
	endfunction

	////////////////////////////////////////////////////////////
	// schedule recurrence
	////////////////////////////////////////////////////////////

	// W(t+16) from W(t+14), W(t+9), W(t+1) and W(t)
	assign w_new = ssig1(win[`SHA_WIN_DEPTH-2])
	             + win[`SHA_WIN_DEPTH-7]
	             + ssig0(win[`SHA_WIN_DEPTH-15])
	             + win[0];

	assign w = win[0];

	// the first 16 appended words only matter once they reach the head
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win <= '0;
		end else if (load) begin
			win <= block;
		end else if (step) begin
			win <= {win[1:`SHA_WIN_DEPTH-1], w_new};
		end
	end

endmodule

// ==== rtl/sha_round.sv ====
`timescale 1ns/1ps

module sha_round (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          load,
	input  logic                          step,
	input  sha_types_pkg::sha_state_u     init_state,
	input  sha_types_pkg::sha_word_t      w,
	input  sha_types_pkg::sha_round_idx_t round_idx,
	output sha_types_pkg::sha_state_u     state
);

	sha_types_pkg::sha_word_t   k;
	sha_types_pkg::sha_word_t   bsig0;
	sha_types_pkg::sha_word_t   bsig1;
	sha_types_pkg::sha_word_t   ch;
	sha_types_pkg::sha_word_t   maj;
	sha_types_pkg::sha_word_t   t1;
	sha_types_pkg::sha_word_t   t2;
	sha_types_pkg::sha_state_u  nxt;

	////////////////////////////////////////////////////////////
	// round functions
	////////////////////////////////////////////////////////////

	function automatic sha_types_pkg::sha_word_t big_sig0(input sha_types_pkg::sha_word_t x);
		return ({x[1:0], x[31:2]}) ^ ({x[12:0], x[31:13]}) ^ ({x[21:0], x[31:22]});
	endfunction

	function automatic sha_types_pkg::sha_word_t big_sig1(input sha_types_pkg::sha_word_t x);
		return ({x[5:0], x[31:6]}) ^ ({x[10:0], x[31:11]}) ^ ({x[24:0], x[31:25]});
	endfunction

	// constant lookup for the current round
	assign k = sha_const_pkg::sha_round_k[round_idx];

	assign bsig0 = big_sig0(state.named.a);
	assign bsig1 = big_sig1(state.named.e);

	// choose: f where e is set, g elsewhere
	assign ch  = (state.named.e & state.named.f) ^ (~state.named.e & state.named.g);
	// majority of a, b, c
	assign maj = (state.named.a & state.named.b)
	           ^ (state.named.a & state.named.c)
	           ^ (state.named.b & state.named.c);

	assign t1 = state.named.h + bsig1 + ch + k + w;
	assign t2 = bsig0 + maj;

	////////////////////////////////////////////////////////////
	// next working state
	////////////////////////////////////////////////////////////

	always_comb begin
		nxt.named.a = t1 + t2;
		nxt.named.b = state.named.a;
		nxt.named.c = state.named.b;
		nxt.named.d = state.named.c;
		nxt.named.e = state.named.d + t1;
		nxt.named.f = state.named.e;
		nxt.named.g = state.named.f;
		nxt.named.h = state.named.g;
	end

	// held after round 63 until the next load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= '0;
		end else if (load) begin
			state <= init_state;
		end else if (step) begin
			state <= nxt;
		end
	end

endmodule

// ==== rtl/sha256_core.sv ====
`timescale 1ns/1ps

module sha256_core (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      en,
	input  sha_types_pkg::sha_state_u init_state,
	input  sha_types_pkg::sha_block_t block,
	output logic                      rdy,
	output sha_types_pkg::sha_state_u digest
);

	logic                          load;
	logic                          step;
	sha_types_pkg::sha_round_idx_t round_idx;
	sha_types_pkg::sha_word_t      w;

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	sha_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.rdy       (rdy),
		.load      (load),
		.step      (step),
		.round_idx (round_idx)
	);

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	// one schedule word per round
	sha_msg_schedule u_sched (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (load),
		.step  (step),
		.block (block),
		.w     (w)
	);

	// working register drives the digest directly
	sha_round u_round (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.step       (step),
		.init_state (init_state),
		.w          (w),
		.round_idx  (round_idx),
		.state      (digest)
	);

endmodule

// ==== testbench/sha256_assertions.sv ====
`timescale 1ns/1ps
`include "sha256_config.svh"

module sha256_assertions (
	input logic                       clk,
	input logic                       rst_n,
	input logic                       en,
	input logic                       rdy,
	input logic [8*`SHA_WORD_W-1:0]   digest
);

	// one cycle per round plus the done cycle
	localparam int BUSY_CYCLES = `SHA_ROUNDS + 1;

	int fail_count = 0;

	////////////////////////////////////////////////////////////
	// en/rdy protocol
	////////////////////////////////////////////////////////////

	property p_busy_window;
		@(posedge clk) disable iff (!rst_n)
		(en && rdy) |=> (!rdy) [*BUSY_CYCLES] ##1 rdy;
	endproperty

	// result holds while idle and not accepting
	property p_digest_hold;
		@(posedge clk) disable iff (!rst_n)
		(rdy && !en) |=> $stable(digest);
	endproperty

	// en while busy neither shortens nor stretches the busy window
	property p_busy_en_ignored;
		@(posedge clk) disable iff (!rst_n)
		$rose(rdy) |-> $past(en && rdy, BUSY_CYCLES + 1);
	endproperty

	// rdy drops only on an accept
	property p_rdy_fall_on_accept;
		@(posedge clk) disable iff (!rst_n)
		$fell(rdy) |-> $past(en && rdy);
	endproperty

	a_busy_window: assert property (p_busy_window)
		else begin
			$error("rdy did not stay low for the full busy window after an accept");
			fail_count++;
		end
	a_digest_hold: assert property (p_digest_hold)
		else begin
			$error("digest changed while the core was idle");
			fail_count++;
		end
	a_busy_en_ignored: assert property (p_busy_en_ignored)
		else begin
			$error("rdy rose without an accept one full busy window earlier");
			fail_count++;
		end
	a_rdy_fall_on_accept: assert property (p_rdy_fall_on_accept)
		else begin
			$error("rdy fell without an accept");
			fail_count++;
		end

endmodule

bind sha256_core sha256_assertions u_assertions (
	.clk    (clk),
	.rst_n  (rst_n),
	.en     (en),
	.rdy    (rdy),
	.digest (digest)
);

// ==== testbench/tb_sha256.sv ====
`timescale 1ns/1ps
`include "sha256_config.svh"

module tb_sha256;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RAND = 40;
	localparam int CHAIN_JOBS = 4;
	localparam int NUM_JOBS = NUM_RAND + 1 + CHAIN_JOBS;
	localparam int BUSY_CYCLES = `SHA_ROUNDS + 1;
	// jobs of 66 cycles plus reset and a 20 percent margin
	localparam int WATCHDOG_NS = (NUM_JOBS * 66 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD) * 12 / 10;
	localparam logic [255:0] ABC_DIGEST =
		256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

	logic                      clk;
	logic                      rst_n;
	logic                      en;
	sha_types_pkg::sha_state_u init_state;
	sha_types_pkg::sha_block_t block;
	logic                      rdy;
	sha_types_pkg::sha_state_u digest;

	logic [31:0] lfsr = 32'h36e2_8ead;
	int value_errs = 0;
	int proto_errs = 0;

	sha256_core UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.en         (en),
		.init_state (init_state),
		.block      (block),
		.rdy        (rdy),
		.digest     (digest)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all jobs finished");
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1 in right-shift form
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) begin
			s = s ^ 32'h8020_0003;
		end
		return s;
	endfunction

	task automatic take_bits(input int n, output logic [511:0] bits);
		bits = '0;
		repeat (n) begin
			lfsr = lfsr_next(lfsr);
			bits = {bits[510:0], lfsr[0]};
		end
	endtask

	task automatic random_job(output sha_types_pkg::sha_state_u st,
	                          output sha_types_pkg::sha_block_t blk);
		logic [511:0] bits;
		take_bits(256, bits);
		st.flat = bits[255:0];
		take_bits(512, bits);
		blk = bits;
	endtask

	function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// 64 rounds without feed-forward
	task automatic compress_ref(input sha_types_pkg::sha_state_u st,
	                            input sha_types_pkg::sha_block_t blk,
	                            output sha_types_pkg::sha_state_u res);
		logic [31:0] ws [0:63];
		logic [31:0] a, b, c, d, e, f, g, h, t1, t2;
		int t;
		for (t = 0; t < 16; t++) begin
			ws[t] = blk[t];
		end
		for (t = 16; t < 64; t++) begin
			ws[t] = (rotr(ws[t-2], 17) ^ rotr(ws[t-2], 19) ^ (ws[t-2] >> 10)) + ws[t-7]
			      + (rotr(ws[t-15], 7) ^ rotr(ws[t-15], 18) ^ (ws[t-15] >> 3)) + ws[t-16];
		end
		{a, b, c, d, e, f, g, h} = st.flat;
		for (t = 0; t < 64; t++) begin
			t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g))
			   + sha_const_pkg::sha_round_k[t] + ws[t];
			t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
			h = g;
			g = f;
			f = e;
			e = d + t1;
			d = c;
			c = b;
			b = a;
			a = t1 + t2;
		end
		res.flat = {a, b, c, d, e, f, g, h};
	endtask

	////////////////////////////////////////////////////////////
	// job sequencing
	////////////////////////////////////////////////////////////

	// runs from just after the accept edge to the negedge where rdy is back
	task automatic track_job(input sha_types_pkg::sha_state_u exp, input bit noise,
	                         input bit keep_en, input sha_types_pkg::sha_state_u nst,
	                         input sha_types_pkg::sha_block_t nblk);
		logic [511:0] bits;
		int cycles;
		bit seen;
		cycles = 0;
		seen = 0;
		while (!seen && cycles <= BUSY_CYCLES + 4) begin
			if (cycles < `SHA_ROUNDS && noise) begin
				take_bits(1, bits);
				en <= bits[0];
				take_bits(256, bits);
				init_state <= bits[255:0];
				take_bits(512, bits);
				block <= bits;
			end else if (cycles < `SHA_ROUNDS) begin
				if (!keep_en) begin
					en <= 1'b0;
				end
			end else if (keep_en) begin
				// next job is taken on the cycle after rdy rises
				en <= 1'b1;
				init_state <= nst;
				block <= nblk;
			end else begin
				en <= 1'b0;
			end
			@(negedge clk);
			if (rdy) begin
				seen = 1;
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
		assert (seen && cycles == BUSY_CYCLES)
			else begin
				proto_errs++;
				$display("rdy was low for %0d cycles after an accept instead of %0d",
				         cycles, BUSY_CYCLES);
			end
		if (seen) begin
			assert (digest.flat === exp.flat)
				else begin
					value_errs++;
					$display("ERR digest exp=%h act=%h", exp.flat, digest.flat);
				end
		end
	endtask

	task automatic run_job(input sha_types_pkg::sha_state_u st,
	                       input sha_types_pkg::sha_block_t blk,
	                       input sha_types_pkg::sha_state_u exp, input bit noise);
		logic [511:0] bits;
		take_bits(2, bits);
		repeat (int'(bits[1:0])) @(posedge clk);
		@(posedge clk);
		en <= 1'b1;
		init_state <= st;
		block <= blk;
		// accept edge
		@(posedge clk);
		track_job(exp, noise, 1'b0, '0, '0);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		sha_types_pkg::sha_state_u st;
		sha_types_pkg::sha_state_u nst;
		sha_types_pkg::sha_state_u exp;
		sha_types_pkg::sha_state_u nexp;
		sha_types_pkg::sha_block_t blk;
		sha_types_pkg::sha_block_t nblk;
		logic [255:0] sum;
		int assert_errs;
		int j;
		int i;

		rst_n <= 1'b0;
		en <= 1'b0;
		init_state <= '0;
		block <= '0;
		nst = '0;
		nblk = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		assert (rdy === 1'b1)
			else begin
				value_errs++;
				$display("ERR rdy exp=%h act=%h", 1'b1, rdy);
			end
		assert (digest.flat === '0)
			else begin
				value_errs++;
				$display("ERR digest exp=%h act=%h", 256'h0, digest.flat);
			end

		// odd jobs also toggle en and the inputs while busy
		for (j = 0; j < NUM_RAND; j++) begin
			random_job(st, blk);
			compress_ref(st, blk, exp);
			run_job(st, blk, exp, j[0]);
		end

		// padded "abc"
		st = sha_const_pkg::sha_iv;
		blk = '0;
		blk[0] = 32'h6162_6380;
		blk[15] = 32'h0000_0018;
		compress_ref(st, blk, exp);
		run_job(st, blk, exp, 1'b0);
		for (i = 0; i < 8; i++) begin
			sum[255-32*i -: 32] = digest.flat[255-32*i -: 32] + st.flat[255-32*i -: 32];
		end
		assert (sum === ABC_DIGEST)
			else begin
				value_errs++;
				$display("ERR digest+iv exp=%h act=%h", ABC_DIGEST, sum);
			end

		// back to back with en held high
		random_job(st, blk);
		compress_ref(st, blk, exp);
		@(posedge clk);
		en <= 1'b1;
		init_state <= st;
		block <= blk;
		@(posedge clk);
		for (j = 0; j < CHAIN_JOBS; j++) begin
			if (j < CHAIN_JOBS - 1) begin
				random_job(nst, nblk);
				compress_ref(nst, nblk, nexp);
			end
			track_job(exp, 1'b0, j < CHAIN_JOBS - 1, nst, nblk);
			if (j < CHAIN_JOBS - 1) begin
				@(posedge clk);
				exp = nexp;
			end
		end

		repeat (4) @(posedge clk);
		assert_errs = UUT.u_assertions.fail_count;
		$display("value errors: %0d, protocol errors: %0d, assertion errors: %0d",
		         value_errs, proto_errs, assert_errs);
		if (value_errs == 0 && proto_errs == 0 && assert_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/sha_types_pkg.sv
rtl/sha_const_pkg.sv
rtl/sha_ctrl.sv
rtl/sha_msg_schedule.sv
rtl/sha_round.sv
rtl/sha256_core.sv
testbench/sha256_assertions.sv
testbench/tb_sha256.sv
